// File: dv/lsu_checker.sv
// Concurrent assertions on the load/store unit ports, bound to the top level
`timescale 1ns/10ps

module lsu_checker
    import isa_pkg::*, lsu_pkg::*;
(
    input logic       clk,
    input logic       i_rst,
    input issue_t     i_issue,
    input load_resp_t i_load,
    input logic       i_sq_full,
    input logic       i_sq_empty
);

    logic load_issued;
    logic store_issued;

    assign load_issued  = i_issue.valid && (i_issue.opcode == OPCODE_LOAD);
    assign store_issued = i_issue.valid && (i_issue.opcode == OPCODE_STORE);

    // Outputs settle after the first reset edge
    quiet_in_reset: assert property (@(posedge clk)
        i_rst && $past(i_rst) |-> !i_load.valid && !i_sq_full)
        else $error("Load valid or store queue full high during reset");

    no_store_when_full: assert property (@(posedge clk) disable iff (i_rst)
        store_issued |-> !i_sq_full)
        else $error("Store issued while the store queue is full");

    // One-cycle load latency
    load_gets_response: assert property (@(posedge clk) disable iff (i_rst)
        load_issued |=> i_load.valid)
        else $error("Load issued without a response on the next cycle");

    full_and_empty_exclusive: assert property (@(posedge clk) disable iff (i_rst)
        !(i_sq_full && i_sq_empty))
        else $error("Store queue full and empty at the same time");

endmodule

bind lsu_top lsu_checker lsu_checker_inst (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_issue    (i_issue),
    .i_load     (o_load),
    .i_sq_full  (o_sq_full),
    .i_sq_empty (o_sq_empty)
);

// File: dv/lsu_tb.sv
// Load/store unit testbench driven from a trace of issues, commits
// and flag checks, with the expected load results in the same file
`timescale 1ns/10ps

module lsu_tb
    import isa_pkg::*, lsu_pkg::*;
();

    localparam int FIELDS     = 6;
    localparam int MAX_ROWS   = 64;
    localparam int WAIT_LIMIT = 50;

    localparam logic [31:0] KIND_IDLE   = 32'h0;
    localparam logic [31:0] KIND_ISSUE  = 32'h1;
    localparam logic [31:0] KIND_COMMIT = 32'h2;
    localparam logic [31:0] KIND_FLAGS  = 32'h3;
    localparam logic [31:0] KIND_END    = 32'hF;

    logic        clk;
    logic        i_rst;
    issue_t      i_issue;
    logic        i_commit;
    load_resp_t  o_load;
    logic        o_sq_full;
    logic        o_sq_empty;

    logic [31:0] trace_mem [FIELDS*MAX_ROWS];
    logic [31:0] pending_tag[$];
    logic [31:0] pending_data[$];
    int          errors = 0;

    tb_clock_gen tb_clock_gen_inst (
        .o_clk (clk)
    );

    lsu_top lsu_top_inst (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_issue    (i_issue),
        .i_commit   (i_commit),
        .o_load     (o_load),
        .o_sq_full  (o_sq_full),
        .o_sq_empty (o_sq_empty)
    );

    task automatic stop_with_failure(input string reason);
        errors++;
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h",
                                        name, actual, expected));
        end
    endtask

    // Advance to the next falling edge and check any load response
    task automatic next_cycle();
        logic [31:0] exp_tag;
        logic [31:0] exp_data;
        @(negedge clk);
        if (o_load.valid) begin
            if (pending_tag.size() == 0) begin
                stop_with_failure("Load response arrived with no load outstanding");
            end else begin
                exp_tag  = pending_tag.pop_front();
                exp_data = pending_data.pop_front();
                check_value("o_load.tag", 32'(o_load.tag), exp_tag);
                check_value("o_load.data", o_load.data, exp_data);
            end
        end
    endtask

    task automatic wait_sq_not_full();
        int cycles;
        cycles = 0;
        while (o_sq_full) begin
            if (cycles == WAIT_LIMIT) begin
                stop_with_failure("Timed out waiting for the store queue to leave full");
            end else begin
                next_cycle();
                cycles++;
            end
        end
    endtask

    task automatic drive_issue(input int row);
        logic [31:0] insn_word;
        insn_word      = trace_mem[FIELDS*row + 1];
        i_issue.valid  = 1'b1;
        i_issue.opcode = opcode_t'(insn_word[6:0]);
        i_issue.insn   = insn_u'(insn_word);
        i_issue.src_a  = trace_mem[FIELDS*row + 2];
        i_issue.src_b  = trace_mem[FIELDS*row + 3];
        i_issue.tag    = trace_mem[FIELDS*row + 4][TAG_WIDTH-1:0];
        if (insn_word[6:0] == OPCODE_LOAD) begin
            pending_tag.push_back(trace_mem[FIELDS*row + 4]);
            pending_data.push_back(trace_mem[FIELDS*row + 5]);
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (pending_tag.size() != 0) begin
            if (cycles == WAIT_LIMIT) begin
                stop_with_failure("Timed out waiting for outstanding load responses");
            end else begin
                next_cycle();
                cycles++;
            end
        end
        cycles = 0;
        while (!o_sq_empty) begin
            if (cycles == WAIT_LIMIT) begin
                stop_with_failure("Timed out waiting for the store queue to empty");
            end else begin
                next_cycle();
                cycles++;
            end
        end
    endtask

    initial begin
        int          row;
        logic [31:0] kind;
        bit          done;
        row      = 0;
        done     = 1'b0;
        i_rst    = 1'b1;
        i_issue  = '0;
        i_commit = 1'b0;
        $readmemh("dv/lsu_trace.txt", trace_mem);
        repeat (10) @(negedge clk);
        i_rst = 1'b0;

        while (!done && row < MAX_ROWS) begin
            kind = trace_mem[FIELDS*row];
            next_cycle();
            i_issue  = '0;
            i_commit = 1'b0;
            case (kind)
                KIND_IDLE: begin
                end
                KIND_ISSUE: begin
                    if (trace_mem[FIELDS*row + 1][6:0] == OPCODE_STORE) begin
                        wait_sq_not_full();
                    end
                    drive_issue(row);
                end
                KIND_COMMIT: i_commit = 1'b1;
                KIND_FLAGS: begin
                    check_value("{o_sq_full, o_sq_empty}", {30'b0, o_sq_full, o_sq_empty},
                                trace_mem[FIELDS*row + 5]);
                end
                KIND_END: done = 1'b1;
                default: stop_with_failure("Unknown entry kind in the trace");
            endcase
            row++;
        end
        if (!done) begin
            stop_with_failure("Trace ended without an end marker");
        end
        wait_drained();

        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: dv/lsu_trace.txt
// kind insn src_a src_b tag expected; kind 0 idle, 1 issue, 2 commit, 3 flags, F end
// expected holds load data for a load and {full, empty} for a flags check
1 FE002E23 44 DEADBEEF 00 00000000
2 00000000 00 00000000 00 00000000
1 00802003 38 00000000 01 DEADBEEF
1 FF002003 50 00000000 02 DEADBEEF
1 000000A3 40 AAAAAA55 00 00000000
1 00001123 40 FFFF1234 00 00000000
2 00000000 00 00000000 00 00000000
2 00000000 00 00000000 00 00000000
1 00002003 40 00000000 03 123455EF
1 00002223 40 F1807F85 00 00000000
2 00000000 00 00000000 00 00000000
1 00400003 40 00000000 04 FFFFFF85
1 00604003 40 00000000 05 00000080
1 00601003 40 00000000 06 FFFFF180
1 00605003 40 00000000 07 0000F180
1 00002023 40 11111111 00 00000000
1 FE002C23 48 22222222 00 00000000
1 00002003 40 00000000 08 123455EF
2 00000000 00 00000000 00 00000000
1 00002003 40 00000000 09 11111111
2 00000000 00 00000000 00 00000000
1 00002003 40 00000000 0A 22222222
3 00000000 00 00000000 00 00000001
2 00000000 00 00000000 00 00000000
3 00000000 00 00000000 00 00000001
1 00002023 4C A0000001 00 00000000
1 00002023 50 A0000002 00 00000000
1 00002023 54 A0000003 00 00000000
1 00002023 58 A0000004 00 00000000
3 00000000 00 00000000 00 00000002
2 00000000 00 00000000 00 00000000
3 00000000 00 00000000 00 00000000
2 00000000 00 00000000 00 00000000
2 00000000 00 00000000 00 00000000
2 00000000 00 00000000 00 00000000
3 00000000 00 00000000 00 00000001
1 00002003 58 00000000 0B A0000004
F 00000000 00 00000000 00 00000000

// File: dv/tb_clock_gen.sv
// Free-running testbench clock
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 10.0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) o_clk = ~o_clk;
        end
    end

endmodule

// File: rtl/isa_pkg.sv
// RV32 major opcodes, I-type and S-type instruction formats
// and the instruction word union that views one word both ways
package isa_pkg;

    localparam int XLEN = 32;

    typedef enum logic [6:0] {
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_OP     = 7'b0110011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_BRANCH = 7'b1100011
    } opcode_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } insn_i_t;

    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        opcode_t     opcode;
    } insn_s_t;

    // Loads read the word as I-type, stores as S-type
    typedef union packed {
        insn_i_t i;
        insn_s_t s;
    } insn_u;

endpackage

// File: rtl/lsu_common.svh
// Default store queue depth and data memory size
`ifndef LSU_COMMON_SVH
`define LSU_COMMON_SVH
`define LSU_SQ_DEPTH  4
`define LSU_MEM_WORDS 64
`endif

// File: rtl/lsu_id.sv
// Load/store decode, immediate selection and address generation
`timescale 1ns/10ps

module lsu_id
    import isa_pkg::*, lsu_pkg::*;
(
    // Op from the reservation station
    input  issue_t    i_issue,

    // Request to the memory stage
    output mem_req_t  o_req,

    // Store queue allocation
    output logic      o_sq_alloc_en,
    output sq_entry_t o_sq_alloc
);

    insn_u           insn;
    logic            is_load;
    logic            is_store;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] addr;
    lsu_func_t       func;

    assign insn     = i_issue.insn;
    assign is_load  = i_issue.opcode == OPCODE_LOAD;
    assign is_store = i_issue.opcode == OPCODE_STORE;

    // Sign-extended immediates from both views of the word
    assign imm_i = {{(XLEN-12){insn.i.imm[11]}}, insn.i.imm};
    assign imm_s = {{(XLEN-12){insn.s.imm_hi[6]}}, insn.s.imm_hi, insn.s.imm_lo};

    assign addr = i_issue.src_a + (is_store ? imm_s : imm_i);

    // funct3 sits in the same bits in both formats
    always_comb begin
        func = LSU_FUNC_LW;
        if (is_store) begin
            case (insn.s.funct3)
                3'b000:  func = LSU_FUNC_SB;
                3'b001:  func = LSU_FUNC_SH;
                default: func = LSU_FUNC_SW;
            endcase
        end else if (is_load) begin
            case (insn.i.funct3)
                3'b000:  func = LSU_FUNC_LB;
                3'b001:  func = LSU_FUNC_LH;
                3'b100:  func = LSU_FUNC_LBU;
                3'b101:  func = LSU_FUNC_LHU;
                default: func = LSU_FUNC_LW;
            endcase
        end
    end

    // Other opcodes never reach the memory stage
    assign o_req.valid = i_issue.valid & (is_load | is_store);
    assign o_req.func  = func;
    assign o_req.addr  = addr;
    assign o_req.tag   = i_issue.tag;

    assign o_sq_alloc_en   = i_issue.valid & is_store;
    assign o_sq_alloc.func = func;
    assign o_sq_alloc.addr = addr;
    assign o_sq_alloc.data = i_issue.src_b;

endmodule

// File: rtl/lsu_mem_stage.sv
// Word-addressed data memory with byte-enable store writes and a
// registered load read followed by lane select and extension
`timescale 1ns/10ps

module lsu_mem_stage
    import isa_pkg::*, lsu_pkg::*;
#(
    parameter int MEM_WORDS = 64
) (
    input  logic       clk,
    input  logic       i_rst,

    input  mem_req_t   i_req,
    input  logic       i_wr_en,
    input  sq_entry_t  i_wr,

    output load_resp_t o_load
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [XLEN-1:0]      mem [MEM_WORDS];
    logic [3:0]           be;
    logic [XLEN-1:0]      wdata;
    logic [IDX_W-1:0]     wr_idx;
    logic [IDX_W-1:0]     rd_idx;
    logic                 is_load_req;

    logic                 load_valid;
    logic [XLEN-1:0]      rd_word;
    logic [1:0]           rd_off;
    lsu_func_t            rd_func;
    logic [TAG_WIDTH-1:0] rd_tag;
    logic [7:0]           lane8;
    logic [15:0]          lane16;

    assign wr_idx = i_wr.addr[IDX_W+1:2];
    assign rd_idx = i_req.addr[IDX_W+1:2];
    assign is_load_req = i_req.valid & (i_req.func inside
        {LSU_FUNC_LB, LSU_FUNC_LH, LSU_FUNC_LW, LSU_FUNC_LBU, LSU_FUNC_LHU});

    // Replicate the store data into every lane it may land in
    always_comb begin
        case (i_wr.func)
            LSU_FUNC_SB: begin
                be    = 4'b0001 << i_wr.addr[1:0];
                wdata = {4{i_wr.data[7:0]}};
            end
            LSU_FUNC_SH: begin
                be    = i_wr.addr[1] ? 4'b1100 : 4'b0011;
                wdata = {2{i_wr.data[15:0]}};
            end
            default: begin
                be    = 4'b1111;
                wdata = i_wr.data;
            end
        endcase
    end

    // Read sees the old word when a commit lands on the same edge
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
        if (is_load_req) begin
            rd_word <= mem[rd_idx];
            rd_off  <= i_req.addr[1:0];
            rd_func <= i_req.func;
            rd_tag  <= i_req.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            load_valid <= 1'b0;
        end else begin
            load_valid <= is_load_req;
        end
    end

    assign lane8  = rd_word[{rd_off, 3'b000} +: 8];
    assign lane16 = rd_off[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        o_load.valid = load_valid;
        o_load.tag   = rd_tag;
        case (rd_func)
            LSU_FUNC_LB:  o_load.data = {{(XLEN-8){lane8[7]}}, lane8};
            LSU_FUNC_LBU: o_load.data = {{(XLEN-8){1'b0}}, lane8};
            LSU_FUNC_LH:  o_load.data = {{(XLEN-16){lane16[15]}}, lane16};
            LSU_FUNC_LHU: o_load.data = {{(XLEN-16){1'b0}}, lane16};
            default:      o_load.data = rd_word;
        endcase
    end

endmodule

// File: rtl/lsu_pkg.sv
// Memory function codes, reorder tag width and the structs
// carried between the load/store unit blocks
package lsu_pkg;

    import isa_pkg::*;

    localparam int TAG_WIDTH = 6;

    typedef enum logic [2:0] {
        LSU_FUNC_LB  = 3'd0,
        LSU_FUNC_LH  = 3'd1,
        LSU_FUNC_LW  = 3'd2,
        LSU_FUNC_LBU = 3'd3,
        LSU_FUNC_LHU = 3'd4,
        LSU_FUNC_SB  = 3'd5,
        LSU_FUNC_SH  = 3'd6,
        LSU_FUNC_SW  = 3'd7
    } lsu_func_t;

    // Op as it leaves the reservation station
    typedef struct packed {
        logic                 valid;
        opcode_t              opcode;
        insn_u                insn;
        logic [XLEN-1:0]      src_a;
        logic [XLEN-1:0]      src_b;
        logic [TAG_WIDTH-1:0] tag;
    } issue_t;

    typedef struct packed {
        logic                 valid;
        lsu_func_t            func;
        logic [XLEN-1:0]      addr;
        logic [TAG_WIDTH-1:0] tag;
    } mem_req_t;

    typedef struct packed {
        lsu_func_t            func;
        logic [XLEN-1:0]      addr;
        logic [XLEN-1:0]      data;
    } sq_entry_t;

    typedef struct packed {
        logic                 valid;
        logic [TAG_WIDTH-1:0] tag;
        logic [XLEN-1:0]      data;
    } load_resp_t;

endpackage

// File: rtl/lsu_store_queue.sv
// In-order store queue, filled at issue and drained one entry per commit
`timescale 1ns/10ps

module lsu_store_queue
    import lsu_pkg::*;
#(
    parameter int SQ_DEPTH = 4
) (
    input  logic      clk,
    input  logic      i_rst,

    input  logic      i_alloc_en,
    input  sq_entry_t i_alloc,
    input  logic      i_commit,

    // Oldest entry, written to memory at the commit edge
    output logic      o_wr_en,
    output sq_entry_t o_wr,

    output logic      o_full,
    output logic      o_empty
);

    localparam int PTR_W = (SQ_DEPTH > 1) ? $clog2(SQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(SQ_DEPTH + 1);

    sq_entry_t        entries [SQ_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign o_full  = count == CNT_W'(SQ_DEPTH);
    assign o_empty = count == '0;

    // Stores issued while full are lost
    assign push = i_alloc_en & ~o_full;
    assign pop  = i_commit & ~o_empty;

    assign o_wr_en = pop;
    assign o_wr    = entries[head];

    always_ff @(posedge clk) begin
        if (push) begin
            entries[tail] <= i_alloc;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= (tail == PTR_W'(SQ_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == PTR_W'(SQ_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: rtl/lsu_top.sv
// Load/store unit top level with decode, store queue and memory stage
`timescale 1ns/10ps
`include "lsu_common.svh"

module lsu_top
    import lsu_pkg::*;
#(
    parameter int SQ_DEPTH  = `LSU_SQ_DEPTH,
    parameter int MEM_WORDS = `LSU_MEM_WORDS
) (
    input  logic       clk,
    input  logic       i_rst,

    input  issue_t     i_issue,
    input  logic       i_commit,

    output load_resp_t o_load,
    output logic       o_sq_full,
    output logic       o_sq_empty
);

    mem_req_t  req;
    logic      sq_alloc_en;
    sq_entry_t sq_alloc;
    logic      sq_wr_en;
    sq_entry_t sq_wr;

    lsu_id lsu_id_inst (
        .i_issue       (i_issue),
        .o_req         (req),
        .o_sq_alloc_en (sq_alloc_en),
        .o_sq_alloc    (sq_alloc)
    );

    lsu_store_queue #(
        .SQ_DEPTH (SQ_DEPTH)
    ) lsu_store_queue_inst (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_alloc_en (sq_alloc_en),
        .i_alloc    (sq_alloc),
        .i_commit   (i_commit),
        .o_wr_en    (sq_wr_en),
        .o_wr       (sq_wr),
        .o_full     (o_sq_full),
        .o_empty    (o_sq_empty)
    );

    lsu_mem_stage #(
        .MEM_WORDS (MEM_WORDS)
    ) lsu_mem_stage_inst (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_req   (req),
        .i_wr_en (sq_wr_en),
        .i_wr    (sq_wr),
        .o_load  (o_load)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the load/store unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module lsu_tb -o lsu_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/lsu_sim > sim.log 2>&1 || echo "Test failures found" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0

// File: src.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/lsu_pkg.sv
rtl/lsu_id.sv
rtl/lsu_store_queue.sv
rtl/lsu_mem_stage.sv
rtl/lsu_top.sv
dv/tb_clock_gen.sv
dv/lsu_checker.sv
dv/lsu_tb.sv
